//--- project.f
+incdir+.
fe_types_pkg.sv
fe_bus_pkg.sv
instr_scan.sv
bht.sv
next_pc.sv
instr_queue.sv
frontend.sv
tb_icache_model.sv
tb_frontend.sv

//--- run.sh
#!/bin/sh
# Build the fetch frontend testbench with Verilator and run it.
# The run counts as failed when the log holds the testbench's failure line.

cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_frontend \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_frontend > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; } \
  || echo "simulation finished without failures"

//--- tb_frontend.sv
// Fetch frontend testbench
// Directed tests for sequential fetch, JAL prediction, BHT learning,
// mispredict redirect and decode credit back-pressure.

`timescale 1ns/1ps
`include "fe_params.svh"

module tb_frontend;

  localparam fe_types_pkg::vaddr_t BOOT_ADDR = 32'h0000_0100;
  localparam fe_types_pkg::vaddr_t JAL_PC    = 32'h0000_0204;
  localparam fe_types_pkg::vaddr_t BR_PC     = 32'h0000_0300;
  localparam int                   TIMEOUT   = 200;

  logic                     clk_i;
  logic                     rst_ni;
  fe_types_pkg::vaddr_t     boot_addr;
  fe_bus_pkg::icache_req_t  icache_req;
  fe_bus_pkg::icache_rsp_t  icache_rsp;
  fe_bus_pkg::bp_resolve_t  resolve;
  fe_bus_pkg::fetch_entry_t fetch_entry;
  logic                     fetch_valid;
  logic                     decode_credit = 1'b0;

  // decode side bookkeeping
  fe_bus_pkg::fetch_entry_t got_q [$];
  int                       owed        = 0;
  logic                     hold        = 1'b0;
  logic                     credit_next = 1'b0;

  frontend frontend_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .boot_addr_i     (boot_addr),
    .icache_req_o    (icache_req),
    .icache_rsp_i    (icache_rsp),
    .resolve_i       (resolve),
    .fetch_entry_o   (fetch_entry),
    .fetch_valid_o   (fetch_valid),
    .decode_credit_i (decode_credit)
  );

  tb_icache_model icache_model_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (icache_req),
    .rsp_o  (icache_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // collect entries in the middle of the cycle, where the port is stable,
  // and give each credit back one cycle later unless held
  initial begin : decode_side
    forever begin
      @(negedge clk_i);
      #1;
      credit_next = 1'b0;
      if (!hold && (owed > 0)) begin
        credit_next = 1'b1;
        owed--;
      end
      if (fetch_valid) begin
        got_q.push_back(fetch_entry);
        owed++;
      end
      decode_credit = credit_next;
    end
  end

  // ----------------------------------------------------------------------
  // checks and helpers
  // ----------------------------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_entry(input string name, input fe_bus_pkg::fetch_entry_t got,
                             input fe_bus_pkg::fetch_entry_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input fe_types_pkg::vaddr_t got,
                            input fe_types_pkg::vaddr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  function automatic fe_bus_pkg::fetch_entry_t expected_entry(
    input fe_types_pkg::vaddr_t pc, input fe_types_pkg::instr_t instr,
    input fe_types_pkg::cf_e cf, input logic taken, input fe_types_pkg::vaddr_t target);
    fe_bus_pkg::fetch_entry_t e;
    e.pc          = pc;
    e.instr       = instr;
    e.cf          = cf;
    e.pred_taken  = taken;
    e.pred_target = target;
    return e;
  endfunction

  // op-imm word whose immediate bits mix the whole address
  function automatic fe_types_pkg::instr_t fill_word(input fe_types_pkg::vaddr_t addr);
    return {addr[31:7] ^ addr[24:0], 7'b0010011};
  endfunction

  function automatic fe_types_pkg::instr_t encode_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
  endfunction

  // beq x1, x2
  function automatic fe_types_pkg::instr_t encode_beq(input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic write_word(input fe_types_pkg::vaddr_t addr, input fe_types_pkg::instr_t w);
    icache_model_inst.prog[addr[9:2]] = w;
  endtask

  task automatic load_program();
    fe_types_pkg::vaddr_t addr;
    for (int i = 0; i < 256; i++) begin
      addr = fe_types_pkg::vaddr_t'(i * 4);
      write_word(addr, fill_word(addr));
    end
    write_word(JAL_PC, encode_jal(21'h0003C));
    // offset -32, back to 0x2e0
    write_word(BR_PC, encode_beq(13'h1FE0));
  endtask

  task automatic wait_entries(input int n);
    int cycles;
    cycles = 0;
    while ((got_q.size() < n) && (cycles < TIMEOUT)) begin
      @(negedge clk_i);
      cycles++;
    end
    if (got_q.size() < n) begin
      stop_on_error("timeout while waiting for a fetch entry");
    end
  endtask

  task automatic next_entry(output fe_bus_pkg::fetch_entry_t e);
    wait_entries(1);
    e = got_q.pop_front();
  endtask

  task automatic expect_plain(input fe_types_pkg::vaddr_t pc);
    fe_bus_pkg::fetch_entry_t e;
    next_entry(e);
    check_entry("fetch_entry_o", e,
                expected_entry(pc, fill_word(pc), fe_types_pkg::NO_CF, 1'b0, pc + 32'd4));
  endtask

  // one-cycle resolve event; a mispredict makes earlier entries stale
  task automatic send_resolve(input fe_types_pkg::vaddr_t pc, input logic is_branch,
                              input logic taken, input logic mispredict,
                              input fe_types_pkg::vaddr_t target);
    @(negedge clk_i);
    resolve.valid      = 1'b1;
    resolve.pc         = pc;
    resolve.is_branch  = is_branch;
    resolve.taken      = taken;
    resolve.mispredict = mispredict;
    resolve.target     = target;
    if (mispredict) begin
      got_q.delete();
    end
    @(negedge clk_i);
    resolve = '0;
  endtask

  task automatic restart(input fe_types_pkg::vaddr_t target);
    send_resolve(target, 1'b0, 1'b0, 1'b1, target);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_sequential();
    for (int n = 0; n < 8; n++) begin
      expect_plain(BOOT_ADDR + fe_types_pkg::vaddr_t'(4 * n));
    end
  endtask

  task automatic test_jal();
    fe_bus_pkg::fetch_entry_t e;
    restart(32'h0000_0200);
    expect_plain(32'h0000_0200);
    next_entry(e);
    check_entry("fetch_entry_o", e, expected_entry(JAL_PC, encode_jal(21'h0003C),
                fe_types_pkg::JUMP, 1'b1, JAL_PC + 32'h3C));
    expect_plain(JAL_PC + 32'h3C);
  endtask

  task automatic check_branch(input logic taken);
    fe_bus_pkg::fetch_entry_t e;
    fe_types_pkg::vaddr_t     target;
    target = taken ? BR_PC - 32'h20 : BR_PC + 32'd4;
    restart(BR_PC);
    next_entry(e);
    check_entry("fetch_entry_o", e, expected_entry(BR_PC, encode_beq(13'h1FE0),
                fe_types_pkg::BRANCH, taken, target));
    expect_plain(target);
  endtask

  task automatic test_bht();
    // counter out of reset is weakly not taken
    check_branch(1'b0);
    send_resolve(BR_PC, 1'b1, 1'b1, 1'b0, BR_PC - 32'h20);
    check_branch(1'b1);
    send_resolve(BR_PC, 1'b1, 1'b0, 1'b0, BR_PC + 32'd4);
    send_resolve(BR_PC, 1'b1, 1'b0, 1'b0, BR_PC + 32'd4);
    check_branch(1'b0);
  endtask

  task automatic test_mispredict();
    fe_bus_pkg::fetch_entry_t e;
    restart(32'h0000_0140);
    next_entry(e);
    check_addr("fetch_entry_o.pc", e.pc, 32'h0000_0140);
    next_entry(e);
    check_addr("fetch_entry_o.pc", e.pc, 32'h0000_0144);
    send_resolve(32'h0000_0144, 1'b1, 1'b1, 1'b1, 32'h0000_0380);
    for (int n = 0; n < 4; n++) begin
      expect_plain(32'h0000_0380 + fe_types_pkg::vaddr_t'(4 * n));
    end
  endtask

  task automatic test_backpressure();
    int cycles;
    restart(32'h0000_0180);
    // let the credits still in flight reach the frontend
    cycles = 0;
    while ((owed != 0) && (cycles < TIMEOUT)) begin
      @(negedge clk_i);
      cycles++;
    end
    if (owed != 0) begin
      stop_on_error("decode credits were not returned before the hold");
    end
    hold = 1'b1;
    wait_entries(`FE_DECODE_CREDITS);
    repeat (20) @(negedge clk_i);
    if (got_q.size() != `FE_DECODE_CREDITS) begin
      stop_on_error("wrong number of entries delivered while credits were held");
    end
    hold = 1'b0;
    for (int n = 0; n < 6; n++) begin
      expect_plain(32'h0000_0180 + fe_types_pkg::vaddr_t'(4 * n));
    end
  endtask

  initial begin : main
    rst_ni    = 1'b0;
    boot_addr = BOOT_ADDR;
    resolve   = '0;
    load_program();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    // first cycle after release, before the request can be accepted
    #1;
    if ((icache_req.valid !== 1'b1) || (icache_req.kill !== 1'b0) ||
        (fetch_valid !== 1'b0)) begin
      stop_on_error("cache request or decode port wrong in the first cycle after reset");
    end
    check_addr("icache_req_o.vaddr", icache_req.vaddr, BOOT_ADDR);
    @(negedge clk_i);
    test_sequential();
    test_jal();
    test_bht();
    test_mispredict();
    test_backpressure();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- tb_icache_model.sv
// Instruction cache model
// Takes one request at a time and answers from a program array after 1 to 3
// cycles. The latency comes from a Galois LFSR. A kill drops the pending
// answer, so no response is sent for that request.

`timescale 1ns/1ps

module tb_icache_model (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  fe_bus_pkg::icache_req_t req_i,
  output fe_bus_pkg::icache_rsp_t rsp_o
);

  localparam int unsigned WORDS = 256;

  // program words, indexed by address bits 9:2 and written by the tests
  fe_types_pkg::instr_t prog [WORDS];

  fe_bus_pkg::icache_rsp_t rsp_q = '0;
  fe_types_pkg::vaddr_t    addr_q;
  logic [7:0]              lfsr_q;
  logic [1:0]              wait_q;
  logic                    busy_q;

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  assign rsp_o = rsp_q;

  // ----------------------------------------------------------------------
  // accept, latency countdown and kill
  // ----------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin : track
    logic [7:0] s;
    logic [1:0] lat;
    if (!rst_ni) begin
      busy_q <= 1'b0;
      wait_q <= '0;
      addr_q <= '0;
      lfsr_q <= 8'd10;
    end else if (req_i.kill || rsp_q.valid) begin
      busy_q <= 1'b0;
    end else if (req_i.valid && rsp_q.ready) begin
      // one lfsr step per latency bit
      s      = lfsr_step(lfsr_q);
      lat[0] = s[0];
      s      = lfsr_step(s);
      lat[1] = s[0];
      lfsr_q <= s;
      busy_q <= 1'b1;
      addr_q <= req_i.vaddr;
      // a draw of 0 counts as 1 cycle
      wait_q <= (lat == 2'd0) ? 2'd0 : lat - 2'd1;
    end else if (busy_q && (wait_q != 2'd0)) begin
      wait_q <= wait_q - 2'd1;
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk_i) begin
    rsp_q.ready <= !busy_q;
    rsp_q.valid <= busy_q && (wait_q == 2'd0);
    rsp_q.vaddr <= addr_q;
    rsp_q.data  <= prog[addr_q[9:2]];
  end

endmodule

//--- frontend.sv
// RV32I fetch frontend
// Fetches one word per cache request, scans it for control flow, predicts
// branches with a BHT and queues fetch entries toward decode. A mispredict
// from execute kills the cache request and empties the queue.

`timescale 1ns/1ps

module frontend (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  fe_types_pkg::vaddr_t     boot_addr_i,
  output fe_bus_pkg::icache_req_t  icache_req_o,
  input  fe_bus_pkg::icache_rsp_t  icache_rsp_i,
  input  fe_bus_pkg::bp_resolve_t  resolve_i,
  output fe_bus_pkg::fetch_entry_t fetch_entry_o,
  output logic                     fetch_valid_o,
  input  logic                     decode_credit_i
);

  fe_bus_pkg::icache_req_t  icache_req;
  fe_bus_pkg::fetch_entry_t entry;
  fe_types_pkg::cf_e        cf;
  fe_types_pkg::vaddr_t     imm;
  fe_types_pkg::vaddr_t     predicted_next;
  logic                     bht_taken;
  logic                     pred_taken;
  logic                     mispredict;
  logic                     rsp_valid;
  logic                     slot_free;
  logic                     reserve;

  assign mispredict = resolve_i.valid && resolve_i.mispredict;
  // a response racing a redirect belongs to the wrong path
  assign rsp_valid  = icache_rsp_i.valid && !mispredict;
  assign reserve    = icache_req.valid && icache_rsp_i.ready;

  assign icache_req_o = icache_req;

  // ----------------------------------------------------------------------
  // scan and predict
  // ----------------------------------------------------------------------
  instr_scan instr_scan_inst (
    .instr_i (icache_rsp_i.data),
    .cf_o    (cf),
    .imm_o   (imm)
  );

  bht bht_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_pc_i    (icache_rsp_i.vaddr),
    .taken_o        (bht_taken),
    .update_valid_i (resolve_i.valid && resolve_i.is_branch),
    .update_pc_i    (resolve_i.pc),
    .update_taken_i (resolve_i.taken)
  );

  // jalr stays not taken without a target predictor
  always_comb begin
    unique case (cf)
      fe_types_pkg::BRANCH: pred_taken = bht_taken;
      fe_types_pkg::JUMP:   pred_taken = 1'b1;
      default:              pred_taken = 1'b0;
    endcase
  end

  assign predicted_next = pred_taken ? icache_rsp_i.vaddr + imm
                                     : icache_rsp_i.vaddr + fe_types_pkg::vaddr_t'(4);

  assign entry.pc          = icache_rsp_i.vaddr;
  assign entry.instr       = icache_rsp_i.data;
  assign entry.cf          = cf;
  assign entry.pred_taken  = pred_taken;
  assign entry.pred_target = predicted_next;

  // ----------------------------------------------------------------------
  // fetch address and queue
  // ----------------------------------------------------------------------
  next_pc next_pc_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .boot_addr_i      (boot_addr_i),
    .rsp_valid_i      (rsp_valid),
    .predicted_next_i (predicted_next),
    .redirect_i       (mispredict),
    .redirect_pc_i    (resolve_i.target),
    .slot_free_i      (slot_free),
    .icache_req_o     (icache_req),
    .icache_ready_i   (icache_rsp_i.ready)
  );

  instr_queue instr_queue_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (mispredict),
    .push_i          (rsp_valid),
    .entry_i         (entry),
    .reserve_i       (reserve),
    .slot_free_o     (slot_free),
    .decode_credit_i (decode_credit_i),
    .fetch_entry_o   (fetch_entry_o),
    .fetch_valid_o   (fetch_valid_o)
  );

endmodule

//--- instr_queue.sv
// Instruction queue
// FIFO of fetch entries between the cache response and decode. Keeps one
// slot reserved for the request in flight and a credit count toward decode.

`timescale 1ns/1ps
`include "fe_params.svh"

module instr_queue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     push_i,
  input  fe_bus_pkg::fetch_entry_t entry_i,
  input  logic                     reserve_i,
  output logic                     slot_free_o,
  input  logic                     decode_credit_i,
  output fe_bus_pkg::fetch_entry_t fetch_entry_o,
  output logic                     fetch_valid_o
);

  localparam int unsigned DEPTH    = `FE_QUEUE_DEPTH;
  localparam int unsigned PTR_W    = $clog2(DEPTH);
  localparam int unsigned CNT_W    = $clog2(DEPTH + 1);
  localparam int unsigned CREDIT_W = $clog2(`FE_DECODE_CREDITS + 1);

  localparam logic [CNT_W-1:0]    DEPTH_CNT   = CNT_W'(DEPTH);
  localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(`FE_DECODE_CREDITS);

  fe_bus_pkg::fetch_entry_t mem_q [DEPTH];

  logic [PTR_W-1:0]    wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]    count_q, count_d;
  logic [CNT_W-1:0]    used;
  logic                reserved_q;
  logic [CREDIT_W-1:0] credit_q, credit_d;
  logic                pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // reserved slot counts as taken so a response always finds room
  assign used        = count_q + CNT_W'(reserved_q);
  assign slot_free_o = (used < DEPTH_CNT);

  // nothing older than a redirect leaves the queue
  assign pop           = (count_q != '0) && (credit_q != '0) && !flush_i;
  assign fetch_valid_o = pop;
  assign fetch_entry_o = mem_q[rd_ptr_q];

  always_comb begin
    count_d = count_q;
    if (push_i && !pop) begin
      count_d = count_q + 1'b1;
    end else if (!push_i && pop) begin
      count_d = count_q - 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // decode credits, untouched by a flush
  // ----------------------------------------------------------------------
  always_comb begin
    credit_d = credit_q;
    if (pop && !decode_credit_i) begin
      credit_d = credit_q - 1'b1;
    end else if (!pop && decode_credit_i) begin
      credit_d = credit_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      reserved_q <= 1'b0;
      credit_q   <= CREDIT_INIT;
    end else begin
      credit_q <= credit_d;
      if (flush_i) begin
        wr_ptr_q   <= '0;
        rd_ptr_q   <= '0;
        count_q    <= '0;
        reserved_q <= 1'b0;
      end else begin
        if (push_i) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        count_q <= count_d;
        if (reserve_i) begin
          reserved_q <= 1'b1;
        end else if (push_i) begin
          reserved_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

//--- next_pc.sv
// Next fetch address
// Holds the fetch address and the outstanding-request flag, chooses between
// redirect, predicted next pc and boot address, and drives the cache request.

`timescale 1ns/1ps

module next_pc (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  fe_types_pkg::vaddr_t     boot_addr_i,
  input  logic                     rsp_valid_i,
  input  fe_types_pkg::vaddr_t     predicted_next_i,
  input  logic                     redirect_i,
  input  fe_types_pkg::vaddr_t     redirect_pc_i,
  input  logic                     slot_free_i,
  output fe_bus_pkg::icache_req_t  icache_req_o,
  input  logic                     icache_ready_i
);

  fe_types_pkg::vaddr_t addr_q, addr_d;
  fe_types_pkg::vaddr_t fetch_addr;
  // set until the boot address has been sent or overridden
  logic boot_q, boot_d;
  logic outstanding_q, outstanding_d;
  logic req_valid;
  logic accept;

  assign fetch_addr = boot_q ? boot_addr_i : addr_q;

  // a request issued during a redirect would carry a stale address
  assign req_valid = !outstanding_q && slot_free_i && !redirect_i;
  assign accept    = req_valid && icache_ready_i;

  assign icache_req_o.valid = req_valid;
  assign icache_req_o.vaddr = fetch_addr;
  assign icache_req_o.kill  = redirect_i && outstanding_q;

  // ----------------------------------------------------------------------
  // address selection, redirect wins over a response
  // ----------------------------------------------------------------------
  always_comb begin
    addr_d        = addr_q;
    boot_d        = boot_q;
    outstanding_d = outstanding_q;
    if (redirect_i) begin
      addr_d        = redirect_pc_i;
      boot_d        = 1'b0;
      outstanding_d = 1'b0;
    end else if (rsp_valid_i) begin
      addr_d        = predicted_next_i;
      outstanding_d = 1'b0;
    end else if (accept) begin
      // keep the address in flight so the boot mux can be released
      addr_d        = fetch_addr;
      boot_d        = 1'b0;
      outstanding_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q        <= '0;
      boot_q        <= 1'b1;
      outstanding_q <= 1'b0;
    end else begin
      addr_q        <= addr_d;
      boot_q        <= boot_d;
      outstanding_q <= outstanding_d;
    end
  end

endmodule

//--- bht.sv
// Branch history table
// A direct-mapped table of 2-bit saturating counters. Lookup is
// combinational, updates from execute are written at the clock edge.

`timescale 1ns/1ps
`include "fe_params.svh"

module bht (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  fe_types_pkg::vaddr_t lookup_pc_i,
  output logic                 taken_o,
  input  logic                 update_valid_i,
  input  fe_types_pkg::vaddr_t update_pc_i,
  input  logic                 update_taken_i
);

  fe_types_pkg::bht_cnt_t cnt_q [`FE_BHT_ENTRIES];
  fe_types_pkg::bht_idx_t lookup_idx;
  fe_types_pkg::bht_idx_t update_idx;
  fe_types_pkg::bht_cnt_t update_cnt;

  // word aligned pcs, bits 1:0 carry no information
  assign lookup_idx = lookup_pc_i[`FE_BHT_IDX_W+1:2];
  assign update_idx = update_pc_i[`FE_BHT_IDX_W+1:2];

  assign taken_o = cnt_q[lookup_idx][1];

  // ----------------------------------------------------------------------
  // counter update
  // ----------------------------------------------------------------------
  always_comb begin
    update_cnt = cnt_q[update_idx];
    if (update_taken_i) begin
      if (update_cnt != 2'b11) begin
        update_cnt = update_cnt + 2'd1;
      end
    end else begin
      if (update_cnt != 2'b00) begin
        update_cnt = update_cnt - 2'd1;
      end
    end
  end

  // weakly not taken out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (update_valid_i) begin
      cnt_q[update_idx] <= update_cnt;
    end
  end

endmodule

//--- instr_scan.sv
// Instruction scanner
// Classifies one RV32I word as branch, JAL, JALR or plain instruction and
// extracts the sign-extended B-type or J-type offset.

`timescale 1ns/1ps
`include "fe_params.svh"

module instr_scan (
  input  fe_types_pkg::instr_t instr_i,
  output fe_types_pkg::cf_e    cf_o,
  output fe_types_pkg::vaddr_t imm_o
);

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic [6:0]  opcode;
  logic [12:0] imm_b;
  logic [20:0] imm_j;

  assign opcode = instr_i[6:0];

  // offsets are in units of bytes with bit 0 always zero
  assign imm_b = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    cf_o  = fe_types_pkg::NO_CF;
    imm_o = '0;
    unique case (opcode)
      OPC_BRANCH: begin
        cf_o  = fe_types_pkg::BRANCH;
        imm_o = {{(`FE_VLEN-13){imm_b[12]}}, imm_b};
      end
      OPC_JAL: begin
        cf_o  = fe_types_pkg::JUMP;
        imm_o = {{(`FE_VLEN-21){imm_j[20]}}, imm_j};
      end
      // target depends on a register, so no offset is formed
      OPC_JALR: begin
        cf_o = fe_types_pkg::JUMPR;
      end
      default: begin
        cf_o = fe_types_pkg::NO_CF;
      end
    endcase
  end

endmodule

//--- fe_bus_pkg.sv
// Fetch frontend port structs
// Packed structs for the instruction cache port, the resolve port from
// execute and the fetch entry handed to decode.

package fe_bus_pkg;

  // request from the frontend toward the instruction cache
  typedef struct packed {
    logic                 valid;
    fe_types_pkg::vaddr_t vaddr;
    logic                 kill;
  } icache_req_t;

  // cache answer, vaddr is echoed from the request
  typedef struct packed {
    logic                 ready;
    logic                 valid;
    fe_types_pkg::vaddr_t vaddr;
    fe_types_pkg::instr_t data;
  } icache_rsp_t;

  // branch resolution from execute, valid is a single-cycle event
  typedef struct packed {
    logic                 valid;
    fe_types_pkg::vaddr_t pc;
    logic                 is_branch;
    logic                 taken;
    logic                 mispredict;
    fe_types_pkg::vaddr_t target;
  } bp_resolve_t;

  // one instruction with its prediction, as seen by decode
  typedef struct packed {
    fe_types_pkg::vaddr_t pc;
    fe_types_pkg::instr_t instr;
    fe_types_pkg::cf_e    cf;
    logic                 pred_taken;
    fe_types_pkg::vaddr_t pred_target;
  } fetch_entry_t;

endpackage

//--- fe_types_pkg.sv
// Fetch frontend scalar types
// Vector typedefs for addresses, instruction words and predictor state,
// plus the control-flow classification.

`include "fe_params.svh"

package fe_types_pkg;

  // fetch or target address
  typedef logic [`FE_VLEN-1:0] vaddr_t;

  // one RV32I instruction word
  typedef logic [31:0] instr_t;

  // branch history table index, taken from pc bits above bit 1
  typedef logic [`FE_BHT_IDX_W-1:0] bht_idx_t;

  // 2-bit saturating counter, msb set means predict taken
  typedef logic [1:0] bht_cnt_t;

  // control-flow class of a fetched instruction
  typedef enum logic [1:0] {
    NO_CF,
    BRANCH,
    JUMP,
    JUMPR
  } cf_e;

endpackage

//--- fe_params.svh
// Fetch frontend parameters
// Address width, queue sizing, decode credits and branch history table size
// shared by the packages and the RTL.

`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// virtual address width
`define FE_VLEN 32

// instruction queue entries
`define FE_QUEUE_DEPTH 4

// credits held toward decode right after reset
`define FE_DECODE_CREDITS 2

// branch history table, counter count and index width
`define FE_BHT_ENTRIES 16
`define FE_BHT_IDX_W 4

`endif
